/* hdl/adc_conversion.sv */
`timescale 1ns/1ps

module adc_conversion import az_pkg::*; #(
  parameter int ADC_W = 16
) (
  input  logic                clk,
  input  logic                reset,
  // request from the sequencer
  input  logic                meas_req,
  input  logic [AZMUX_W-1:0]  azmux,
  // external converter
  output logic                adc_start,
  input  logic                adc_ready,
  input  logic [ADC_W-1:0]    adc_data,
  // completed conversion
  output logic                meas_done,
  output logic [ADC_W-1:0]    meas_code,
  output logic                meas_is_hi
);

  typedef enum logic {
    conv_idle,
    conv_busy
  } conv_state_e;

  conv_state_e state;

  always_ff @(posedge clk or posedge reset)
    if (reset)
    begin
      state      <= conv_idle;
      adc_start  <= 1'b0;
      meas_done  <= 1'b0;
      meas_is_hi <= 1'b0;
    end
    else
    begin
      // both strobes last one cycle
      adc_start <= 1'b0;
      meas_done <= 1'b0;

      case (state)
        conv_idle:
          if (meas_req)
          begin
            state     <= conv_busy;
            adc_start <= 1'b1;
            // mux is already settled on the side being measured
            meas_is_hi <= (azmux == AZMUX_HI_VAL);
          end

        // converter delay varies, adc_ready ends it
        conv_busy:
          if (adc_ready)
          begin
            state     <= conv_idle;
            meas_done <= 1'b1;
          end

        default:
          state <= conv_idle;
      endcase
    end

  // code register, valid with meas_done
  always_ff @(posedge clk)
    if (state == conv_busy && adc_ready)
      meas_code <= adc_data;

  // one conversion in flight at a time
  a_no_req_while_busy: assert property (
    @(posedge clk) disable iff (reset) meas_req |-> (state == conv_idle)
  );

endmodule

/* hdl/az_apb_regs.sv */
`timescale 1ns/1ps

module az_apb_regs import az_pkg::*; #(
  parameter int ADC_W   = 16,
  parameter int COUNT_W = 24
) (
  input  logic                clk,
  input  logic                reset,
  // apb slave
  input  logic [APB_AW-1:0]   paddr,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  logic [APB_DW-1:0]   pwdata,
  output logic [APB_DW-1:0]   prdata,
  output logic                pready,
  output logic                pslverr,
  // readback from the result stage
  input  logic [ADC_W:0]      result,
  input  logic [PAIR_W-1:0]   pair_count,
  // configuration levels to the sequencer
  output logic                run,
  output logic [COUNT_W-1:0]  precharge_n,
  output logic [AZMUX_W-1:0]  azmux_lo_val
);

  logic addr_ok;
  logic wr_en;

  // no wait states, every transfer is setup plus one access cycle
  assign pready = 1'b1;

  // write lands at the end of the access cycle
  assign wr_en = psel & penable & pwrite;

  always_ff @(posedge clk or posedge reset)
    if (reset)
    begin
      run          <= 1'b0;
      precharge_n  <= COUNT_W'(PRECHARGE_DEF);
      azmux_lo_val <= AZMUX_LO_DEF;
    end
    else if (wr_en)
    begin
      // result and pair count are read only, writes there are ignored
      case (paddr)
        reg_ctrl:      run          <= pwdata[0];
        reg_precharge: precharge_n  <= pwdata[COUNT_W-1:0];
        reg_lo_sel:    azmux_lo_val <= pwdata[AZMUX_W-1:0];
        default:       ;
      endcase
    end

  ////////////////////
  // read mux, valid through the access cycle
  always_comb
  begin
    prdata  = '0;
    addr_ok = 1'b1;
    case (paddr)
      reg_ctrl:       prdata[0]           = run;
      reg_precharge:  prdata[COUNT_W-1:0] = precharge_n;
      reg_lo_sel:     prdata[AZMUX_W-1:0] = azmux_lo_val;
      // difference is signed, extend it over the bus
      reg_result:     prdata = {{(APB_DW-ADC_W-1){result[ADC_W]}}, result};
      reg_pair_count: prdata[PAIR_W-1:0]  = pair_count;
      default:        addr_ok = 1'b0;
    endcase
  end

  // unknown offsets read zero and flag an error in the access cycle
  assign pslverr = psel & penable & ~addr_ok;

  // access phase never appears without a select
  a_penable_with_psel: assert property (
    @(posedge clk) disable iff (reset) penable |-> psel
  );

endmodule

/* hdl/az_pkg.sv */
package az_pkg;

  ////////////////////
  // widths

  // apb address and data
  localparam int APB_AW = 5;
  localparam int APB_DW = 32;

  // auto-zero mux, enable bit on top, select below
  localparam int AZMUX_W = 4;

  // completed pair counter
  localparam int PAIR_W = 16;

  ////////////////////
  // switch and mux constants

  // precharge switch levels
  localparam logic SW_PC_BOOT   = 1'b0;
  localparam logic SW_PC_SIGNAL = 1'b1;

  // s1 selects the precharge output as the high side
  localparam logic [AZMUX_W-1:0] AZMUX_HI_VAL = 4'b1000;

  // s3 as the low side until software picks another input
  localparam logic [AZMUX_W-1:0] AZMUX_LO_DEF = 4'b1010;

  // 500us at a 20MHz clock
  localparam int PRECHARGE_DEF = 10000;

  ////////////////////
  // sequencer states, a load state followed by its wait state
  typedef enum logic [3:0] {
    s_idle,
    s_protect,
    s_protect_wait,
    s_settle,
    s_settle_wait,
    s_meas_hi,
    s_meas_hi_wait,
    s_reprotect,
    s_reprotect_wait,
    s_meas_lo,
    s_meas_lo_wait,
    s_cycle_end
  } az_state_e;

  // apb register byte offsets
  typedef enum logic [APB_AW-1:0] {
    reg_ctrl       = 5'h00,
    reg_precharge  = 5'h04,
    reg_lo_sel     = 5'h08,
    reg_result     = 5'h0C,
    reg_pair_count = 5'h10
  } reg_addr_e;

endpackage

/* hdl/az_result.sv */
`timescale 1ns/1ps

module az_result import az_pkg::*; #(
  parameter int ADC_W = 16
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               meas_done,
  input  logic [ADC_W-1:0]   meas_code,
  input  logic               meas_is_hi,
  output logic [ADC_W:0]     result,
  output logic [PAIR_W-1:0]  pair_count
);

  logic [ADC_W-1:0]  hi_code;
  logic              hi_valid;
  logic [ADC_W:0]    diff;

  // one extra bit so hi minus lo never wraps
  assign diff = $signed({1'b0, hi_code}) - $signed({1'b0, meas_code});

  always_ff @(posedge clk or posedge reset)
    if (reset)
    begin
      hi_valid   <= 1'b0;
      result     <= '0;
      pair_count <= '0;
    end
    else if (meas_done)
    begin
      if (meas_is_hi)
        hi_valid <= 1'b1;
      else if (hi_valid)
      begin
        // the pair is consumed
        hi_valid   <= 1'b0;
        result     <= diff;
        pair_count <= pair_count + 1'b1;
      end
      // stray lo without a hi is dropped
    end

  // latest hi code, replaced by each new hi reading
  always_ff @(posedge clk)
    if (meas_done && meas_is_hi)
      hi_code <= meas_code;

endmodule

/* hdl/az_sequencer.sv */
`timescale 1ns/1ps

module az_sequencer import az_pkg::*; #(
  parameter int COUNT_W = 24
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                run,
  input  logic [COUNT_W-1:0]  precharge_n,
  input  logic [AZMUX_W-1:0]  azmux_lo_val,
  input  logic                meas_done,
  output logic                sw_pc_ctl,
  output logic [AZMUX_W-1:0]  azmux,
  output logic                meas_req,
  output logic [1:0]          monitor
);

  az_state_e           state;
  logic [COUNT_W-1:0]  count_down;

  // hi mux is not touched here
  // the high side reaches the az mux through the precharge switch
  always_ff @(posedge clk or posedge reset)
    if (reset)
    begin
      state      <= s_idle;
      count_down <= '0;
      sw_pc_ctl  <= SW_PC_BOOT;
      azmux      <= AZMUX_HI_VAL;
      meas_req   <= 1'b0;
      monitor    <= 2'b00;
    end
    else
    begin
      // request is a single cycle strobe
      meas_req <= 1'b0;

      // phase timer only runs down, it stops at zero
      if (count_down != '0)
        count_down <= count_down - 1'b1;

      case (state)
        s_idle:
          if (run)
            state <= s_protect;

        ////////////////////
        // boot the precharge switch, signal protected from az charge injection
        s_protect:
        begin
          state      <= s_protect_wait;
          count_down <= precharge_n;
          sw_pc_ctl  <= SW_PC_BOOT;
          monitor    <= 2'b00;
        end
        s_protect_wait:
          if (count_down == '0)
            state <= s_settle;

        ////////////////////
        // az mux over to pc out while still protected, the settle phase
        s_settle:
        begin
          state      <= s_settle_wait;
          count_down <= precharge_n;
          azmux      <= AZMUX_HI_VAL;
          monitor[0] <= 1'b1;
        end
        s_settle_wait:
          if (count_down == '0)
            state <= s_meas_hi;

        ////////////////////
        // switch to signal, take the hi reading
        s_meas_hi:
        begin
          state      <= s_meas_hi_wait;
          sw_pc_ctl  <= SW_PC_SIGNAL;
          monitor[1] <= 1'b1;
          meas_req   <= 1'b1;
        end
        // conversion time set by the adc
        s_meas_hi_wait:
          if (meas_done)
            state <= s_reprotect;

        // back to boot before the mux moves
        s_reprotect:
        begin
          state      <= s_reprotect_wait;
          count_down <= precharge_n;
          sw_pc_ctl  <= SW_PC_BOOT;
          monitor[1] <= 1'b0;
        end
        s_reprotect_wait:
          if (count_down == '0)
            state <= s_meas_lo;

        ////////////////////
        // az mux to the configured lo input, take the lo reading
        s_meas_lo:
        begin
          state      <= s_meas_lo_wait;
          azmux      <= azmux_lo_val;
          monitor[0] <= 1'b0;
          meas_req   <= 1'b1;
        end
        s_meas_lo_wait:
          if (meas_done)
            state <= s_cycle_end;

        // run is only checked here, so a cycle always completes
        s_cycle_end:
          state <= run ? s_protect : s_idle;

        default:
          state <= s_idle;
      endcase
    end

  // mux must not move while the switch passes the signal
  a_azmux_stable_on_signal: assert property (
    @(posedge clk) disable iff (reset)
      (sw_pc_ctl == SW_PC_SIGNAL) |-> $stable(azmux)
  );

endmodule

/* hdl/az_top.sv */
`timescale 1ns/1ps

module az_top import az_pkg::*; #(
  parameter int ADC_W   = 16,
  parameter int COUNT_W = 24
) (
  input  logic                clk,
  input  logic                reset,
  // apb
  input  logic [APB_AW-1:0]   paddr,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  logic [APB_DW-1:0]   pwdata,
  output logic [APB_DW-1:0]   prdata,
  output logic                pready,
  output logic                pslverr,
  // analog front end
  output logic                sw_pc_ctl,
  output logic [AZMUX_W-1:0]  azmux,
  output logic [1:0]          monitor,
  // converter
  output logic                adc_start,
  input  logic                adc_ready,
  input  logic [ADC_W-1:0]    adc_data
);

  logic                run;
  logic [COUNT_W-1:0]  precharge_n;
  logic [AZMUX_W-1:0]  azmux_lo_val;
  logic                meas_req;
  logic                meas_done;
  logic [ADC_W-1:0]    meas_code;
  logic                meas_is_hi;
  logic [ADC_W:0]      result;
  logic [PAIR_W-1:0]   pair_count;

  ////////////////////
  // input side
  az_apb_regs #(
    .ADC_W   (ADC_W),
    .COUNT_W (COUNT_W)
  ) u_az_apb_regs (
    .clk          (clk),
    .reset        (reset),
    .paddr        (paddr),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .result       (result),
    .pair_count   (pair_count),
    .run          (run),
    .precharge_n  (precharge_n),
    .azmux_lo_val (azmux_lo_val)
  );

  ////////////////////
  // processing
  az_sequencer #(
    .COUNT_W (COUNT_W)
  ) u_az_sequencer (
    .clk          (clk),
    .reset        (reset),
    .run          (run),
    .precharge_n  (precharge_n),
    .azmux_lo_val (azmux_lo_val),
    .meas_done    (meas_done),
    .sw_pc_ctl    (sw_pc_ctl),
    .azmux        (azmux),
    .meas_req     (meas_req),
    .monitor      (monitor)
  );

  adc_conversion #(
    .ADC_W (ADC_W)
  ) u_adc_conversion (
    .clk        (clk),
    .reset      (reset),
    .meas_req   (meas_req),
    .azmux      (azmux),
    .adc_start  (adc_start),
    .adc_ready  (adc_ready),
    .adc_data   (adc_data),
    .meas_done  (meas_done),
    .meas_code  (meas_code),
    .meas_is_hi (meas_is_hi)
  );

  ////////////////////
  // output side
  az_result #(
    .ADC_W (ADC_W)
  ) u_az_result (
    .clk        (clk),
    .reset      (reset),
    .meas_done  (meas_done),
    .meas_code  (meas_code),
    .meas_is_hi (meas_is_hi),
    .result     (result),
    .pair_count (pair_count)
  );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build the auto-zero front end testbench with verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing --timescale 1ns/1ps \
  --top-module tb_az_top \
  -f vlog.f \
  -Mdir obj_dir \
  -o sim_az

# the log decides the outcome, not the exit code of the simulator
./obj_dir/sim_az | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* tests/adc_stub.sv */
`timescale 1ns/1ps

module adc_stub import az_pkg::*; #(
  parameter int ADC_W = 16,
  parameter int DELAY = 5
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                adc_start,
  input  logic [AZMUX_W-1:0]  azmux,
  // codes the testbench wants to see on each side
  input  logic [ADC_W-1:0]    hi_code,
  input  logic [ADC_W-1:0]    lo_code,
  output logic                adc_ready,
  output logic [ADC_W-1:0]    adc_data
);

  logic busy;
  int   count;

  always_ff @(posedge clk or posedge reset)
    if (reset)
    begin
      busy      <= 1'b0;
      count     <= 0;
      adc_ready <= 1'b0;
      adc_data  <= '0;
    end
    else
    begin
      // ready is a one cycle strobe
      adc_ready <= 1'b0;
      if (adc_start)
      begin
        busy  <= 1'b1;
        count <= DELAY - 1;
      end
      else if (busy)
      begin
        if (count == 0)
        begin
          busy      <= 1'b0;
          adc_ready <= 1'b1;
          // code picked by where the mux sits at the end of the conversion
          adc_data  <= (azmux == AZMUX_HI_VAL) ? hi_code : lo_code;
        end
        else
          count <= count - 1;
      end
    end

endmodule

/* tests/tb_az_top.sv */
`timescale 1ns/1ps

module tb_az_top
  import az_pkg::*;
();

  localparam int ADC_W   = 16;
  localparam int COUNT_W = 24;

  // short phases so a cycle is a few dozen clocks
  localparam int PC_N       = 6;
  localparam int STUB_DELAY = 5;
  localparam logic [AZMUX_W-1:0] LO_SEL = 4'b1011;
  localparam int N_PAIRS    = 5;

  ////////////////////
  // run budget
  localparam int CYCLE_LEN      = 4 * (PC_N + 1) + 2 * STUB_DELAY + 16;
  // 2 ordering runs, the pairs, 2 stop runs and the idle window
  localparam int RUN_COUNT      = 2 + N_PAIRS + 2 + 3;
  localparam int TIMEOUT_CYCLES = RUN_COUNT * CYCLE_LEN + 300;
  localparam int POLL_LIMIT     = CYCLE_LEN;

  logic                clk;
  logic                reset;
  logic [APB_AW-1:0]   paddr;
  logic                psel;
  logic                penable;
  logic                pwrite;
  logic [APB_DW-1:0]   pwdata;
  logic [APB_DW-1:0]   prdata;
  logic                pready;
  logic                pslverr;
  logic                sw_pc_ctl;
  logic [AZMUX_W-1:0]  azmux;
  logic [1:0]          monitor;
  logic                adc_start;
  logic                adc_ready;
  logic [ADC_W-1:0]    adc_data;
  logic [ADC_W-1:0]    hi_code;
  logic [ADC_W-1:0]    lo_code;

  // bookkeeping
  string       cur_test = "startup";
  int          errors = 0;
  int          monitor_errors = 0;
  int          assert_errors = 0;
  int          errors_at_start = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          cycles = 0;
  int          switch_rises = 0;
  int          lo_starts = 0;
  logic        sw_prev;
  logic        start_seen;
  logic [31:0] lcg_state = 32'd59;

  az_top #(
    .ADC_W   (ADC_W),
    .COUNT_W (COUNT_W)
  ) u_az_top (
    .clk       (clk),
    .reset     (reset),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .sw_pc_ctl (sw_pc_ctl),
    .azmux     (azmux),
    .monitor   (monitor),
    .adc_start (adc_start),
    .adc_ready (adc_ready),
    .adc_data  (adc_data)
  );

  adc_stub #(
    .ADC_W (ADC_W),
    .DELAY (STUB_DELAY)
  ) u_adc_stub (
    .clk       (clk),
    .reset     (reset),
    .adc_start (adc_start),
    .azmux     (azmux),
    .hi_code   (hi_code),
    .lo_code   (lo_code),
    .adc_ready (adc_ready),
    .adc_data  (adc_data)
  );

  // 8 ns period
  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("timeout after %0d cycles during test %s", cycles, cur_test);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////
  // apb handshake check

  // no wait states, every access cycle completes the transfer
  apb_no_wait: assert property (
    @(posedge clk) disable iff (reset) (psel && penable) |-> pready
  ) else
  begin
    assert_errors++;
    $display("%s: pready was low in an apb access cycle", cur_test);
  end

  ////////////////////
  // switch and mux checks

  // mux held still while the signal path is open
  mux_stable_on_signal: assert property (
    @(posedge clk) disable iff (reset) (sw_pc_ctl == SW_PC_SIGNAL) |-> $stable(azmux)
  ) else
  begin
    assert_errors++;
    $display("%s: auto-zero mux moved while the switch was at signal", cur_test);
  end

  // hi start inside each signal window, lo starts on the configured input
  always @(negedge clk)
    if (reset)
    begin
      sw_prev    = SW_PC_BOOT;
      start_seen = 1'b0;
    end
    else
    begin
      if (sw_pc_ctl == SW_PC_SIGNAL && sw_prev == SW_PC_BOOT)
      begin
        switch_rises++;
        start_seen = 1'b0;
      end
      if (adc_start)
      begin
        if (sw_pc_ctl == SW_PC_SIGNAL)
        begin
          start_seen = 1'b1;
          assert (azmux == AZMUX_HI_VAL) else
          begin
            monitor_errors++;
            $display("FAIL %s hi side mux: expected %0h actual %0h",
                     cur_test, AZMUX_HI_VAL, azmux);
          end
        end
        else
        begin
          lo_starts++;
          assert (azmux == LO_SEL) else
          begin
            monitor_errors++;
            $display("FAIL %s lo side mux: expected %0h actual %0h", cur_test, LO_SEL, azmux);
          end
        end
      end
      if (sw_pc_ctl == SW_PC_BOOT && sw_prev == SW_PC_SIGNAL)
        assert (start_seen) else
        begin
          monitor_errors++;
          $display("%s: switch went back to boot with no converter start", cur_test);
        end
      sw_prev = sw_pc_ctl;
    end

  ////////////////////
  // helpers

  // 32 bit lcg, constants from the usual c library generator
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic int total_errors();
    return errors + monitor_errors + assert_errors;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else
    begin
      errors++;
      $display("FAIL %s %s: expected %0h actual %0h", cur_test, what, exp, act);
    end
  endtask

  task automatic start_test(input string name);
    cur_test        = name;
    errors_at_start = total_errors();
  endtask

  task automatic finish_test();
    if (total_errors() == errors_at_start)
    begin
      tests_passed++;
      $display("test %s: ok", cur_test);
    end
    else
    begin
      tests_failed++;
      $display("test %s: %0d errors", cur_test, total_errors() - errors_at_start);
    end
  endtask

  // setup cycle, access cycle, then release
  task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] data);
    @(posedge clk);
    paddr   <= addr;
    pwdata  <= data;
    pwrite  <= 1'b1;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  // prdata and pslverr sampled mid access cycle
  task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [31:0] data,
                          output logic err);
    @(posedge clk);
    paddr   <= addr;
    pwrite  <= 1'b0;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    data = prdata;
    err  = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic wait_for_pairs(input int target);
    logic [31:0] rd;
    logic        err;
    int          tries;
    tries = 0;
    apb_read(reg_pair_count, rd, err);
    while (rd != target && tries < POLL_LIMIT)
    begin
      apb_read(reg_pair_count, rd, err);
      tries++;
    end
    check_value("pair count", target, rd);
  endtask

  // run is only looked at in idle and at cycle end, so a pulse gives one cycle
  task automatic run_one_cycle(input int target);
    apb_write(reg_ctrl, 32'd1);
    apb_write(reg_ctrl, 32'd0);
    wait_for_pairs(target);
  endtask

  ////////////////////
  // test sequence
  initial
  begin
    logic [31:0]      rd;
    logic             err;
    int               base;
    int               rises0;
    int               lo0;
    int               exp_diff;
    logic [ADC_W-1:0] hi_v;
    logic [ADC_W-1:0] lo_v;

    reset   <= 1'b1;
    paddr   <= '0;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    pwdata  <= '0;
    hi_code <= '0;
    lo_code <= '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);

    // 1
    start_test("reset state");
    check_value("sw_pc_ctl", 32'(SW_PC_BOOT), 32'(sw_pc_ctl));
    check_value("azmux", 32'(AZMUX_HI_VAL), 32'(azmux));
    check_value("adc_start", 32'd0, 32'(adc_start));
    check_value("monitor", 32'd0, 32'(monitor));
    apb_read(reg_pair_count, rd, err);
    check_value("pair count", 32'd0, rd);
    apb_read(reg_precharge, rd, err);
    check_value("precharge default", 32'(PRECHARGE_DEF), rd);
    finish_test();

    // 2
    start_test("register access");
    apb_write(reg_precharge, 32'(PC_N));
    apb_read(reg_precharge, rd, err);
    check_value("precharge count", 32'(PC_N), rd);
    check_value("precharge pslverr", 32'd0, 32'(err));
    apb_write(reg_lo_sel, 32'(LO_SEL));
    apb_read(reg_lo_sel, rd, err);
    check_value("lo select", 32'(LO_SEL), rd);
    // 0x14 is past the last register
    apb_read(5'h14, rd, err);
    check_value("unused address data", 32'd0, rd);
    check_value("unused address pslverr", 32'd1, 32'(err));
    finish_test();

    // 3
    start_test("switch ordering");
    rises0 = switch_rises;
    lo0    = lo_starts;
    apb_read(reg_pair_count, rd, err);
    base = int'(rd);
    run_one_cycle(base + 1);
    run_one_cycle(base + 2);
    check_value("signal windows", 32'(rises0 + 2), 32'(switch_rises));
    check_value("lo side starts", 32'(lo0 + 2), 32'(lo_starts));
    finish_test();

    // 4
    start_test("auto-zero result");
    for (int i = 0; i < N_PAIRS; i++)
    begin
      lcg_state = lcg_next(lcg_state);
      hi_v      = lcg_state[31:16];
      lcg_state = lcg_next(lcg_state);
      lo_v      = lcg_state[31:16];
      // sequencer is idle here, so the codes change between conversions
      @(posedge clk);
      hi_code <= hi_v;
      lo_code <= lo_v;
      exp_diff = int'(hi_v) - int'(lo_v);
      apb_read(reg_pair_count, rd, err);
      base = int'(rd);
      run_one_cycle(base + 1);
      apb_read(reg_result, rd, err);
      check_value("hi minus lo", 32'(exp_diff), rd);
    end
    finish_test();

    // 5
    start_test("stop on disable");
    apb_read(reg_pair_count, rd, err);
    base = int'(rd);
    apb_write(reg_ctrl, 32'd1);
    wait_for_pairs(base + 1);
    // second cycle is already under way when run drops
    apb_write(reg_ctrl, 32'd0);
    wait_for_pairs(base + 2);
    for (int i = 0; i < 2 * CYCLE_LEN; i++)
    begin
      @(negedge clk);
      assert (!adc_start) else
      begin
        errors++;
        $display("%s: converter started after run was cleared", cur_test);
      end
    end
    apb_read(reg_pair_count, rd, err);
    check_value("final pair count", 32'(base + 2), rd);
    finish_test();

    $display("tests passed %0d failed %0d, errors %0d", tests_passed, tests_failed,
             total_errors());
    if (tests_failed == 0 && total_errors() == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* vlog.f */
hdl/az_pkg.sv
hdl/az_apb_regs.sv
hdl/az_sequencer.sv
hdl/adc_conversion.sv
hdl/az_result.sv
hdl/az_top.sv
tests/adc_stub.sv
tests/tb_az_top.sv
